//--- spi_cfg.svh
`ifndef SPI_CFG_SVH
`define SPI_CFG_SVH

// entries held by each of the tx and rx fifos.
`define SPI_FIFO_DEPTH 16

// chip select lines, one per attached slave.
`define SPI_SLAVES 4

// byte address width of the axi4-lite port.
`define SPI_ADDR_W 5

`endif

//--- spi_pkg.sv
`default_nettype none

`include "spi_cfg.svh"

package spi_pkg;

    // register map, byte addresses of 32-bit words.
    typedef enum logic [`SPI_ADDR_W-1:0] {
        SPI_STATUS       = 'h00,
        SPI_TX_BUFFER    = 'h04,
        SPI_RX_BUFFER    = 'h08,
        SPI_EVENT        = 'h0C,
        SPI_SLAVE_SELECT = 'h10
    } spi_reg_e;

    // status and configuration word, bit 0 is idle.
    typedef struct packed {
        logic [6:0]  reserved;         // reads as zero.
        logic [15:0] divisor;          // bits 24..9.
        logic        bit_order;        // 0 msb first.
        logic        cpol;
        logic        cpha;
        logic        interrupt_enable;
        logic        rx_full;
        logic        rx_empty;
        logic        tx_full;
        logic        tx_empty;
        logic        idle;
    } spi_status_t;

    // what the shift engine needs to run a byte.
    typedef struct packed {
        logic [15:0] divisor;  // sck half period is divisor+1 clocks.
        logic        bit_order;
        logic        cpol;
        logic        cpha;
    } spi_cfg_t;

    // master to slave channels.
    typedef struct packed {
        logic                   awvalid;
        logic [`SPI_ADDR_W-1:0] awaddr;
        logic                   wvalid;
        logic [31:0]            wdata;
        logic [3:0]             wstrb;
        logic                   bready;
        logic                   arvalid;
        logic [`SPI_ADDR_W-1:0] araddr;
        logic                   rready;
    } axil_req_t;

    // slave to master channels.
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

    typedef enum logic [1:0] {SPI_IDLE, SPI_LOAD, SPI_SHIFT, SPI_DONE} spi_state_e;

endpackage

`default_nettype wire

//--- spi_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module spi_fifo #(
    parameter int DEPTH = 16,
    parameter int WIDTH = 8
) (
    input  wire logic             clk_i,
    input  wire logic             rst_n_i,
    input  wire logic             write_i,      // caller gates on full.
    input  wire logic             read_i,       // caller gates on empty.
    input  wire logic [WIDTH-1:0] write_data_i,
    output logic      [WIDTH-1:0] read_data_o,
    output logic                  empty_o,
    output logic                  full_o
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr, rd_ptr;
    logic [AW:0]      count;               // one extra bit so full is reachable.

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (write_i) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (read_i)  rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({write_i, read_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither leaves occupancy alone.
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (write_i) mem[wr_ptr] <= write_data_i;
    end

    assign read_data_o = mem[rd_ptr];  // head shown before the pop.
    assign empty_o     = (count == '0);
    assign full_o      = (count == (AW+1)'(DEPTH));

endmodule

`default_nettype wire

//--- spi_axil_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_cfg.svh"

module spi_axil_slave (
    input  wire logic                 clk_i,
    input  wire logic                 rst_n_i,
    input  wire spi_pkg::axil_req_t   axil_req_i,
    output spi_pkg::axil_rsp_t        axil_rsp_o,
    output logic                      write_o,
    output spi_pkg::spi_reg_e         write_address_o,
    output logic [31:0]               write_data_o,
    output logic [3:0]                write_strobe_o,
    input  wire logic                 write_error_i,
    output logic                      read_o,
    output spi_pkg::spi_reg_e         read_address_o,
    input  wire logic [31:0]          read_data_i,
    input  wire logic                 read_error_i
);
    import spi_pkg::*;

    logic        wr_accept, rd_accept;
    logic        bvalid_q, rvalid_q;
    logic [1:0]  bresp_q, rresp_q;
    logic [31:0] rdata_q;

    // one outstanding response per direction blocks the next transaction.
    assign wr_accept = axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_q;
    assign rd_accept = axil_req_i.arvalid & ~rvalid_q;

    // strobes live for the accept cycle only.
    assign write_o         = wr_accept;
    assign write_address_o = spi_reg_e'({axil_req_i.awaddr[`SPI_ADDR_W-1:2], 2'b00});
    assign write_data_o    = axil_req_i.wdata;
    assign write_strobe_o  = axil_req_i.wstrb;
    assign read_o          = rd_accept;
    assign read_address_o  = spi_reg_e'({axil_req_i.araddr[`SPI_ADDR_W-1:2], 2'b00});

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (wr_accept)              bvalid_q <= 1'b1;
            else if (axil_req_i.bready) bvalid_q <= 1'b0;  // held until taken.
            if (rd_accept)              rvalid_q <= 1'b1;
            else if (axil_req_i.rready) rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_accept) bresp_q <= write_error_i ? 2'b10 : 2'b00;  // slverr or okay.
        if (rd_accept) begin
            rdata_q <= read_data_i;
            rresp_q <= read_error_i ? 2'b10 : 2'b00;
        end
    end

    always_comb begin
        axil_rsp_o.awready = wr_accept;  // address and data taken together.
        axil_rsp_o.wready  = wr_accept;
        axil_rsp_o.bvalid  = bvalid_q;
        axil_rsp_o.bresp   = bresp_q;
        axil_rsp_o.arready = rd_accept;
        axil_rsp_o.rvalid  = rvalid_q;
        axil_rsp_o.rdata   = rdata_q;
        axil_rsp_o.rresp   = rresp_q;
    end

endmodule

`default_nettype wire

//--- spi_registers.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_cfg.svh"

module spi_registers (
    input  wire logic                    clk_i,
    input  wire logic                    rst_n_i,
    output logic                         interrupt_o,
    input  wire logic                    idle_i,
    input  wire logic                    done_i,
    input  wire logic [7:0]              rx_data_i,
    output logic [7:0]                   tx_data_o,
    output logic                         data_ready_o,
    input  wire logic                    tx_read_i,
    input  wire logic                    rx_write_i,
    output spi_pkg::spi_cfg_t            cfg_o,
    output logic [`SPI_SLAVES-1:0]       cs_n_o,
    input  wire logic                    write_i,
    input  wire spi_pkg::spi_reg_e       write_address_i,
    input  wire logic [31:0]             write_data_i,
    input  wire logic [3:0]              write_strobe_i,
    output logic                         write_error_o,
    input  wire logic                    read_i,
    input  wire spi_pkg::spi_reg_e       read_address_i,
    output logic [31:0]                  read_data_o,
    output logic                         read_error_o
);
    import spi_pkg::*;

    spi_cfg_t               cfg_q;
    spi_status_t            status;
    logic                   irq_en_q;
    logic                   event_q, event_d, irq_q;
    logic [`SPI_SLAVES-1:0] ss_q;
    logic                   tx_empty, tx_full, rx_empty, rx_full;
    logic [7:0]             rx_head;

    // rx is read only and tx is write only.
    assign write_error_o = write_i & (write_address_i == SPI_RX_BUFFER);
    assign read_error_o  = read_i & (read_address_i == SPI_TX_BUFFER);

    // configuration bytes follow the status word layout.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cfg_q    <= '0;
            irq_en_q <= 1'b0;
        end else if (write_i && write_address_i == SPI_STATUS) begin
            if (write_strobe_i[0]) begin
                irq_en_q   <= write_data_i[5];
                cfg_q.cpha <= write_data_i[6];
                cfg_q.cpol <= write_data_i[7];
            end
            if (write_strobe_i[1]) begin
                cfg_q.bit_order    <= write_data_i[8];
                cfg_q.divisor[6:0] <= write_data_i[15:9];
            end
            if (write_strobe_i[2]) cfg_q.divisor[14:7] <= write_data_i[23:16];
            if (write_strobe_i[3]) cfg_q.divisor[15]   <= write_data_i[24];
        end
    end

    assign cfg_o = cfg_q;

    always_comb begin
        status                  = '0;
        status.divisor          = cfg_q.divisor;
        status.bit_order        = cfg_q.bit_order;
        status.cpol             = cfg_q.cpol;
        status.cpha             = cfg_q.cpha;
        status.interrupt_enable = irq_en_q;
        status.rx_full          = rx_full;
        status.rx_empty         = rx_empty;
        status.tx_full          = tx_full;
        status.tx_empty         = tx_empty;
        status.idle             = idle_i;
    end

    // writes past a full tx fifo are dropped, status shows full.
    spi_fifo #(.DEPTH(`SPI_FIFO_DEPTH), .WIDTH(8)) tx_fifo (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .write_i      (write_i & write_strobe_i[0] & ~tx_full &
                       (write_address_i == SPI_TX_BUFFER)),
        .read_i       (tx_read_i & ~tx_empty),
        .write_data_i (write_data_i[7:0]),
        .read_data_o  (tx_data_o),
        .empty_o      (tx_empty),
        .full_o       (tx_full)
    );

    assign data_ready_o = ~tx_empty;

    // a bus read of the rx address pops the head.
    spi_fifo #(.DEPTH(`SPI_FIFO_DEPTH), .WIDTH(8)) rx_fifo (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .write_i      (rx_write_i & ~rx_full),
        .read_i       (read_i & ~rx_empty & (read_address_i == SPI_RX_BUFFER)),
        .write_data_i (rx_data_i),
        .read_data_o  (rx_head),
        .empty_o      (rx_empty),
        .full_o       (rx_full)
    );

    // event bit, a direct write wins over a finished transfer.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            event_q <= 1'b0;
            event_d <= 1'b0;
            irq_q   <= 1'b0;
        end else begin
            if (write_i && write_address_i == SPI_EVENT && write_strobe_i[0]) begin
                event_q <= write_data_i[0];
            end else if (done_i && irq_en_q) begin
                event_q <= 1'b1;
            end
            event_d <= event_q;
            irq_q   <= event_q & ~event_d;  // rising edge, one cycle late.
        end
    end

    assign interrupt_o = irq_q;

    // slave select, a set bit pulls its chip select low.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ss_q <= '0;
        end else if (write_i && write_address_i == SPI_SLAVE_SELECT) begin
            for (int i = 0; i < `SPI_SLAVES; i++) begin
                if (write_strobe_i[i/8]) ss_q[i] <= write_data_i[i];
            end
        end
    end

    assign cs_n_o = ~ss_q;

    always_comb begin
        case (read_address_i)
            SPI_STATUS:       read_data_o = status;
            SPI_RX_BUFFER:    read_data_o = {24'b0, rx_head};
            SPI_EVENT:        read_data_o = {31'b0, event_q};
            SPI_SLAVE_SELECT: read_data_o = 32'(ss_q);
            default:          read_data_o = '0;  // tx and unmapped read zero.
        endcase
    end

endmodule

`default_nettype wire

//--- spi_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module spi_shifter (
    input  wire logic              clk_i,
    input  wire logic              rst_n_i,
    input  wire spi_pkg::spi_cfg_t cfg_i,
    input  wire logic              data_ready_i,
    input  wire logic [7:0]        tx_data_i,
    output logic                   tx_read_o,
    output logic [7:0]             rx_data_o,
    output logic                   rx_write_o,
    output logic                   done_o,
    output logic                   idle_o,
    output logic                   sclk_o,
    output logic                   mosi_o,
    input  wire logic              miso_i
);
    import spi_pkg::*;

    spi_state_e  state_q;
    logic [15:0] div_q;
    logic [3:0]  edge_q;       // index of the next sck toggle.
    logic        sclk_q;
    logic [7:0]  tx_q, rx_q;
    logic        busy, tick, leading, sample_edge, drive_edge;

    // load is the setup half period before the first sck edge.
    assign busy    = (state_q == SPI_LOAD) || (state_q == SPI_SHIFT);
    assign tick    = busy && (div_q == cfg_i.divisor);
    assign leading = ~edge_q[0];  // even toggles leave the idle level.

    // cpha 0 samples on leading edges, cpha 1 on trailing ones.
    assign sample_edge = tick & (leading ^ cfg_i.cpha);
    // the first bit sits on mosi from the pop, so toggle 0 never drives.
    assign drive_edge  = tick & ~(leading ^ cfg_i.cpha) & (edge_q != 4'd0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= SPI_IDLE;
            div_q   <= '0;
            edge_q  <= '0;
            sclk_q  <= 1'b0;
        end else begin
            div_q <= (tick || !busy) ? '0 : div_q + 1'b1;
            if (tick) begin
                sclk_q <= ~sclk_q;
                edge_q <= edge_q + 1'b1;  // wraps to 0 after the 16th toggle.
            end
            case (state_q)
                SPI_IDLE: begin
                    sclk_q <= cfg_i.cpol;  // follows cpol while idle.
                    if (data_ready_i) state_q <= SPI_LOAD;
                end
                SPI_LOAD:  if (tick) state_q <= SPI_SHIFT;
                SPI_SHIFT: if (tick && edge_q == 4'd15) state_q <= SPI_DONE;
                default:   state_q <= SPI_IDLE;  // done lasts one cycle.
            endcase
        end
    end

    // data path.
    always_ff @(posedge clk_i) begin
        if (tx_read_o) begin
            tx_q <= tx_data_i;
        end else if (drive_edge) begin
            tx_q <= cfg_i.bit_order ? {1'b0, tx_q[7:1]} : {tx_q[6:0], 1'b0};
        end
        if (sample_edge) begin
            rx_q <= cfg_i.bit_order ? {miso_i, rx_q[7:1]} : {rx_q[6:0], miso_i};
        end
    end

    assign tx_read_o  = (state_q == SPI_IDLE) & data_ready_i;  // pop on first idle cycle.
    assign mosi_o     = cfg_i.bit_order ? tx_q[0] : tx_q[7];
    assign sclk_o     = sclk_q;
    assign rx_data_o  = rx_q;
    assign rx_write_o = (state_q == SPI_DONE);
    assign done_o     = (state_q == SPI_DONE);
    assign idle_o     = (state_q == SPI_IDLE);

endmodule

`default_nettype wire

//--- spi_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_cfg.svh"

module spi_top (
    input  wire logic               clk_i,
    input  wire logic               rst_n_i,
    input  wire spi_pkg::axil_req_t axil_req_i,
    output spi_pkg::axil_rsp_t      axil_rsp_o,
    output logic                    interrupt_o,
    output logic                    sclk_o,
    output logic                    mosi_o,
    input  wire logic               miso_i,
    output logic [`SPI_SLAVES-1:0]  cs_n_o
);
    import spi_pkg::*;

    logic        write, write_error, read, read_error;
    spi_reg_e    write_address, read_address;
    logic [31:0] write_data, read_data;
    logic [3:0]  write_strobe;
    spi_cfg_t    cfg;
    logic        data_ready, tx_read, rx_write, done, idle;
    logic [7:0]  tx_data, rx_data;

    spi_axil_slave u_axil (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .axil_req_i      (axil_req_i),
        .axil_rsp_o      (axil_rsp_o),
        .write_o         (write),
        .write_address_o (write_address),
        .write_data_o    (write_data),
        .write_strobe_o  (write_strobe),
        .write_error_i   (write_error),
        .read_o          (read),
        .read_address_o  (read_address),
        .read_data_i     (read_data),
        .read_error_i    (read_error)
    );

    spi_registers u_regs (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .interrupt_o     (interrupt_o),
        .idle_i          (idle),
        .done_i          (done),
        .rx_data_i       (rx_data),
        .tx_data_o       (tx_data),
        .data_ready_o    (data_ready),
        .tx_read_i       (tx_read),
        .rx_write_i      (rx_write),
        .cfg_o           (cfg),
        .cs_n_o          (cs_n_o),
        .write_i         (write),
        .write_address_i (write_address),
        .write_data_i    (write_data),
        .write_strobe_i  (write_strobe),
        .write_error_o   (write_error),
        .read_i          (read),
        .read_address_i  (read_address),
        .read_data_o     (read_data),
        .read_error_o    (read_error)
    );

    spi_shifter u_shifter (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .cfg_i        (cfg),
        .data_ready_i (data_ready),
        .tx_data_i    (tx_data),
        .tx_read_o    (tx_read),
        .rx_data_o    (rx_data),
        .rx_write_o   (rx_write),
        .done_o       (done),
        .idle_o       (idle),
        .sclk_o       (sclk_o),
        .mosi_o       (mosi_o),
        .miso_i       (miso_i)
    );

endmodule

`default_nettype wire

//--- tb_spi_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_cfg.svh"

module tb_spi_top;
    import spi_pkg::*;

    localparam logic [1:0] OKAY    = 2'b00;
    localparam logic [1:0] SLVERR  = 2'b10;
    localparam int         MAX_DIV = 7;   // divisor of the full fifo test, the slowest.
    localparam int         HS_LIMIT = 16; // cycles allowed for one handshake.
    localparam int         POLL_TRIES = (`SPI_FIFO_DEPTH + 2) * (16 * (MAX_DIV + 1) + 20);

    typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_POLL, OP_IRQ, OP_PINS, OP_MOSI} op_e;

    // one row of the stimulus table.
    typedef struct packed {
        op_e         op;
        spi_reg_e    addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [31:0] exp;    // read data, pulse count or pin levels.
        logic [1:0]  resp;
    } step_t;

    logic                   clk;
    logic                   rst_n;
    axil_req_t              req;
    axil_rsp_t              rsp;
    logic                   irq, sclk, mosi;
    logic [`SPI_SLAVES-1:0] cs_n;

    step_t       steps[$];
    string       names[$];
    logic [15:0] lfsr = 16'd22;
    int          irq_count = 0;
    int          irq_mark = 0;
    int          cycles = 0;
    int          limit = 0;
    int          checks = 0;
    int          mismatches = 0;
    int          failures = 0;

    spi_top uut (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .axil_req_i  (req),
        .axil_rsp_o  (rsp),
        .interrupt_o (irq),
        .sclk_o      (sclk),
        .mosi_o      (mosi),
        .miso_i      (mosi),   // loopback.
        .cs_n_o      (cs_n)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period.
    end

    // pulses are counted mid cycle where the level is settled.
    always @(negedge clk) begin
        if (irq) irq_count <= irq_count + 1;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("TB FAILED");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_byte(output logic [7:0] b);
        int i;
        b = '0;
        for (i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);
            b = {b[6:0], lfsr[0]};  // one step per bit.
        end
    endtask

    // cs_n is the inverse of slave select and interrupt is expected low.
    function automatic logic [31:0] pin_value(input logic [`SPI_SLAVES-1:0] ss, input logic cpol);
        return 32'({~ss, cpol, 1'b0});
    endfunction

    task automatic add_step(input string name, input op_e op, input spi_reg_e addr,
                            input logic [31:0] data, input logic [3:0] strb,
                            input logic [31:0] exp, input logic [1:0] resp);
        step_t s;
        s.op   = op;
        s.addr = addr;
        s.data = data;
        s.strb = strb;
        s.exp  = exp;
        s.resp = resp;
        steps.push_back(s);
        names.push_back(name);
    endtask

    task automatic write_step(input string name, input spi_reg_e addr, input logic [31:0] data,
                              input logic [3:0] strb, input logic [1:0] resp);
        add_step(name, OP_WRITE, addr, data, strb, '0, resp);
    endtask

    task automatic read_step(input string name, input spi_reg_e addr, input logic [31:0] exp,
                             input logic [1:0] resp);
        add_step(name, OP_READ, addr, '0, '0, exp, resp);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            mismatches++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic build_table();
        logic [7:0] b0, b1;
        logic [7:0] fb [`SPI_FIFO_DEPTH + 2];
        logic [6:0] div;
        logic       cpol, cpha, order;
        int         m, k;
        // status layout has flags in 4..0, irq_en 5, cpha 6, cpol 7, order 8 and divisor 24..9.
        read_step("reset status", SPI_STATUS, 32'h0000_000B, OKAY);
        read_step("reset slave select", SPI_SLAVE_SELECT, 32'h0, OKAY);
        add_step("reset pins", OP_PINS, SPI_STATUS, '0, '0, pin_value('0, 1'b0), OKAY);
        write_step("status bytes 0 and 2", SPI_STATUS, 32'hAA55_AAC0, 4'b0101, OKAY);
        read_step("status merge 0 and 2", SPI_STATUS, 32'h0055_00CB, OKAY);
        add_step("sclk idles high", OP_PINS, SPI_STATUS, '0, '0, pin_value('0, 1'b1), OKAY);
        write_step("status byte 3", SPI_STATUS, 32'hFFFF_FFFF, 4'b1000, OKAY);
        read_step("status merge 3", SPI_STATUS, 32'h0155_00CB, OKAY);  // only divisor bit 15.
        write_step("status byte 1", SPI_STATUS, 32'h0000_0300, 4'b0010, OKAY);
        read_step("status merge 1", SPI_STATUS, 32'h0155_03CB, OKAY);
        write_step("status clear", SPI_STATUS, 32'h0, 4'b1111, OKAY);
        read_step("status cleared", SPI_STATUS, 32'h0000_000B, OKAY);
        write_step("slave select", SPI_SLAVE_SELECT, 32'h5, 4'b0001, OKAY);
        read_step("slave select back", SPI_SLAVE_SELECT, 32'h5, OKAY);
        add_step("chip selects", OP_PINS, SPI_STATUS, '0, '0, pin_value(4'h5, 1'b0), OKAY);
        // bus errors leave the fifos alone.
        write_step("rx write error", SPI_RX_BUFFER, 32'h5A, 4'b1111, SLVERR);
        read_step("status after error", SPI_STATUS, 32'h0000_000B, OKAY);
        read_step("tx read error", SPI_TX_BUFFER, 32'h0, SLVERR);
        // one transfer with the interrupt enabled gives one pulse.
        write_step("irq enable", SPI_STATUS, 32'h20, 4'b0001, OKAY);
        random_byte(b0);
        write_step("irq tx byte", SPI_TX_BUFFER, {24'b0, b0}, 4'b0001, OKAY);
        add_step("irq wait idle", OP_POLL, SPI_STATUS, '0, '0, '0, OKAY);
        add_step("irq one pulse", OP_IRQ, SPI_STATUS, '0, '0, 32'd1, OKAY);
        read_step("event set", SPI_EVENT, 32'h1, OKAY);
        write_step("event clear", SPI_EVENT, 32'h0, 4'b0001, OKAY);
        read_step("event cleared", SPI_EVENT, 32'h0, OKAY);
        add_step("no pulse on clear", OP_IRQ, SPI_STATUS, '0, '0, 32'd0, OKAY);
        read_step("irq rx byte", SPI_RX_BUFFER, {24'b0, b0}, OKAY);
        write_step("irq disable", SPI_STATUS, 32'h0, 4'b0001, OKAY);
        random_byte(b0);
        write_step("quiet tx byte", SPI_TX_BUFFER, {24'b0, b0}, 4'b0001, OKAY);
        add_step("quiet wait idle", OP_POLL, SPI_STATUS, '0, '0, '0, OKAY);
        add_step("no pulse when disabled", OP_IRQ, SPI_STATUS, '0, '0, 32'd0, OKAY);
        read_step("event stays clear", SPI_EVENT, 32'h0, OKAY);
        read_step("quiet rx byte", SPI_RX_BUFFER, {24'b0, b0}, OKAY);
        // every cpol/cpha mode in both bit orders, two bytes each.
        for (m = 0; m < 8; m++) begin
            order = m[2];
            cpol  = m[1];
            cpha  = m[0];
            div   = 7'(m % 3);
            random_byte(b0);
            random_byte(b1);
            write_step($sformatf("mode %0d config", m), SPI_STATUS,
                       {16'b0, div, order, cpol, cpha, 6'b0}, 4'b0011, OKAY);
            write_step($sformatf("mode %0d tx 0", m), SPI_TX_BUFFER, {24'b0, b0}, 4'b0001, OKAY);
            // the first bit on mosi is the msb, or the lsb when the order bit is set.
            add_step($sformatf("mode %0d first bit", m), OP_MOSI, SPI_STATUS, '0, '0,
                     32'(order ? b0[0] : b0[7]), OKAY);
            write_step($sformatf("mode %0d tx 1", m), SPI_TX_BUFFER, {24'b0, b1}, 4'b0001, OKAY);
            add_step($sformatf("mode %0d wait", m), OP_POLL, SPI_STATUS, '0, '0, '0, OKAY);
            read_step($sformatf("mode %0d rx 0", m), SPI_RX_BUFFER, {24'b0, b0}, OKAY);
            read_step($sformatf("mode %0d rx 1", m), SPI_RX_BUFFER, {24'b0, b1}, OKAY);
            add_step($sformatf("mode %0d sclk idle", m), OP_PINS, SPI_STATUS, '0, '0,
                     pin_value(4'h5, cpol), OKAY);
        end
        // with a slow engine the first byte is popped and 16 fill the fifo, so the last is dropped.
        write_step("full config", SPI_STATUS, {16'b0, 7'(MAX_DIV), 9'b0}, 4'b0011, OKAY);
        for (k = 0; k < `SPI_FIFO_DEPTH + 2; k++) begin
            random_byte(fb[k]);
            write_step($sformatf("fill tx %0d", k), SPI_TX_BUFFER, {24'b0, fb[k]}, 4'b0001, OKAY);
        end
        read_step("tx full flag", SPI_STATUS, {7'b0, 16'(MAX_DIV), 4'b0, 5'b01100}, OKAY);
        add_step("full drain wait", OP_POLL, SPI_STATUS, '0, '0, '0, OKAY);
        // 17 bytes were sent but rx holds 16.
        read_step("rx full flag", SPI_STATUS, {7'b0, 16'(MAX_DIV), 4'b0, 5'b10011}, OKAY);
        for (k = 0; k < `SPI_FIFO_DEPTH; k++) begin
            read_step($sformatf("drain rx %0d", k), SPI_RX_BUFFER, {24'b0, fb[k]}, OKAY);
        end
        read_step("rx drained", SPI_STATUS, {7'b0, 16'(MAX_DIV), 4'b0, 5'b01011}, OKAY);
    endtask

    task automatic write_reg(input string name, input spi_reg_e addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [1:0] resp);
        int n;
        resp = 2'bxx;
        @(posedge clk);
        #1;
        req.awvalid = 1'b1;
        req.awaddr  = addr;
        req.wvalid  = 1'b1;
        req.wdata   = data;
        req.wstrb   = strb;
        req.bready  = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!rsp.awready && n < HS_LIMIT);
        assert (rsp.awready && rsp.wready) else begin
            failures++;
            $display("%s: write address and data were never accepted", name);
        end
        @(posedge clk);  // accept edge.
        #1;
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!rsp.bvalid && n < HS_LIMIT);
        assert (rsp.bvalid) else begin
            failures++;
            $display("%s: no write response arrived", name);
        end
        resp = rsp.bresp;
        @(posedge clk);
        #1;
        req.bready = 1'b0;
    endtask

    task automatic read_reg(input string name, input spi_reg_e addr,
                            output logic [31:0] data, output logic [1:0] resp);
        int n;
        data = '0;
        resp = 2'bxx;
        @(posedge clk);
        #1;
        req.arvalid = 1'b1;
        req.araddr  = addr;
        req.rready  = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!rsp.arready && n < HS_LIMIT);
        assert (rsp.arready) else begin
            failures++;
            $display("%s: read address was never accepted", name);
        end
        @(posedge clk);
        #1;
        req.arvalid = 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!rsp.rvalid && n < HS_LIMIT);
        assert (rsp.rvalid) else begin
            failures++;
            $display("%s: no read data arrived", name);
        end
        data = rsp.rdata;
        resp = rsp.rresp;
        @(posedge clk);
        #1;
        req.rready = 1'b0;
    endtask

    // waits for idle with the tx fifo empty, bits 0 and 1 of status.
    task automatic poll_idle(input string name);
        logic [31:0] data;
        logic [1:0]  resp;
        int          tries;
        data  = '0;
        tries = 0;
        while (!(data[0] && data[1]) && tries < POLL_TRIES) begin
            read_reg(name, SPI_STATUS, data, resp);
            tries++;
        end
        assert (data[0] && data[1]) else begin
            failures++;
            $display("%s: engine never went idle with the tx fifo empty in %0d polls", name, tries);
        end
    endtask

    task automatic run_step(input int i);
        step_t       s;
        logic [31:0] data;
        logic [1:0]  resp;
        s = steps[i];
        case (s.op)
            OP_WRITE: begin
                write_reg(names[i], s.addr, s.data, s.strb, resp);
                check_value({names[i], " bresp"}, 32'(s.resp), 32'(resp));
            end
            OP_READ: begin
                read_reg(names[i], s.addr, data, resp);
                check_value(names[i], s.exp, data);
                check_value({names[i], " rresp"}, 32'(s.resp), 32'(resp));
            end
            OP_POLL: poll_idle(names[i]);
            OP_IRQ: begin
                repeat (4) @(posedge clk);  // let a late pulse land.
                check_value(names[i], s.exp, 32'(irq_count - irq_mark));
                irq_mark = irq_count;
            end
            OP_MOSI: begin
                @(negedge clk);  // before the second bit is driven.
                check_value(names[i], s.exp, 32'(mosi));
            end
            default: begin
                @(negedge clk);
                check_value(names[i], s.exp, 32'({cs_n, sclk, irq}));
            end
        endcase
    endtask

    initial begin
        int i;
        rst_n = 1'b0;
        req   = '0;
        build_table();
        limit = steps.size() * (16 * (MAX_DIV + 1) + 20);
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (i = 0; i < steps.size(); i++) begin
            run_step(i);
        end
        $display("checks %0d, mismatches %0d, other failures %0d", checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+.
spi_pkg.sv
spi_fifo.sv
spi_axil_slave.sv
spi_registers.sv
spi_shifter.sv
spi_top.sv
tb_spi_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_spi_top
FILELIST  = all.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
